/* common/secv_mem_settings.svh */
// Memory subsystem widths, timer address map and RAM clear default
`ifndef SECV_MEM_SETTINGS_SVH
`define SECV_MEM_SETTINGS_SVH

// RAM geometry of 256 rows of 64 bits
`define SECV_ADDR_WIDTH 8
`define SECV_INST_WIDTH 32
`define SECV_DATA_WIDTH 64

// Port address widths are one bit wider than the row address
`define SECV_IADR_WIDTH (`SECV_ADDR_WIDTH + 1)
`define SECV_DADR_WIDTH (`SECV_ADDR_WIDTH + 1)

// Timer space register indices
`define SECV_MTIME_IDX 0
`define SECV_MTIMECMP_IDX 1

// RAM rows are cleared by reset unless overridden
`define SECV_CLEAR_RAM 1

`endif

/* common/secv_mem_pkg.sv */
// Shared types and byte-lane helpers for the memory subsystem
`include "secv_mem_settings.svh"

package secv_mem_pkg;

    // Target of a data-port request
    typedef enum logic [1:0] {
        REGION_RAM,
        REGION_TIMER,
        REGION_NONE
    } region_e;

    // Machine timer register select
    typedef enum logic [0:0] {
        MTIMER_MTIME,
        MTIMER_MTIMECMP
    } mtimer_reg_e;

    // Replace the selected bytes of old_val with new_val
    function automatic logic [`SECV_DATA_WIDTH-1:0] byte_merge(
        input logic [`SECV_DATA_WIDTH-1:0]   old_val,
        input logic [`SECV_DATA_WIDTH-1:0]   new_val,
        input logic [`SECV_DATA_WIDTH/8-1:0] sel
    );
        logic [`SECV_DATA_WIDTH-1:0] res;
        res = old_val;
        for (int b = 0; b < `SECV_DATA_WIDTH/8; b++) begin
            if (sel[b]) begin
                res[b*8 +: 8] = new_val[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // Zero the bytes that are not selected
    function automatic logic [`SECV_DATA_WIDTH-1:0] byte_mask(
        input logic [`SECV_DATA_WIDTH-1:0]   val,
        input logic [`SECV_DATA_WIDTH/8-1:0] sel
    );
        logic [`SECV_DATA_WIDTH-1:0] res;
        for (int b = 0; b < `SECV_DATA_WIDTH/8; b++) begin
            res[b*8 +: 8] = sel[b] ? val[b*8 +: 8] : 8'h00;
        end
        return res;
    endfunction

endpackage

/* common/wb_if.sv */
// Wishbone classic link between the data-port decoder and one target
`timescale 1ns/1ns
`include "secv_mem_settings.svh"

interface wb_if;

    // Request side
    logic                            cyc;
    logic                            stb;
    logic                            we;
    logic [`SECV_DATA_WIDTH/8-1:0]   sel;
    logic [`SECV_ADDR_WIDTH-1:0]     adr;
    logic [`SECV_DATA_WIDTH-1:0]     dat_w;

    // Response side
    logic [`SECV_DATA_WIDTH-1:0]     dat_r;
    logic                            ack;

    modport master (
        output cyc,
        output stb,
        output we,
        output sel,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  sel,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

    // Response observer for the merger
    modport monitor (
        input  dat_r,
        input  ack
    );

endinterface

/* logic/wb_addr_decoder.sv */
// Data-port address decoder that steers each request to RAM or timer and tags its region
`timescale 1ns/1ns
`include "secv_mem_settings.svh"

module wb_addr_decoder (
    input  logic                            clk_i,
    input  logic                            RESET_MEM,

    // Data port request from the top
    input  logic                            cyc_i,
    input  logic                            stb_i,
    input  logic                            we_i,
    input  logic [`SECV_DATA_WIDTH/8-1:0]   sel_i,
    input  logic [`SECV_DADR_WIDTH-1:0]     adr_i,
    input  logic [`SECV_DATA_WIDTH-1:0]     dat_i,

    // Target links
    wb_if.master                            ram_o,
    wb_if.master                            tmr_o,

    output secv_mem_pkg::region_e           region_q_o
);
    import secv_mem_pkg::*;

    localparam int AW = `SECV_ADDR_WIDTH;
    localparam logic [AW-1:0] MTIME_IDX    = `SECV_MTIME_IDX;
    localparam logic [AW-1:0] MTIMECMP_IDX = `SECV_MTIMECMP_IDX;

    logic          req;
    logic [AW-1:0] idx;
    region_e       region_d;

    assign req = cyc_i && stb_i;
    assign idx = adr_i[AW-1:0];

    // Top address bit picks RAM or timer space
    always_comb begin
        if (!adr_i[`SECV_DADR_WIDTH-1]) begin
            region_d = REGION_RAM;
        end else if (idx == MTIME_IDX || idx == MTIMECMP_IDX) begin
            region_d = REGION_TIMER;
        end else begin
            region_d = REGION_NONE;
        end
    end

    // RAM link with stb only when the RAM is the target
    assign ram_o.cyc   = cyc_i;
    assign ram_o.stb   = stb_i && (region_d == REGION_RAM);
    assign ram_o.we    = we_i;
    assign ram_o.sel   = sel_i;
    assign ram_o.adr   = idx;
    assign ram_o.dat_w = dat_i;

    // Timer link
    assign tmr_o.cyc   = cyc_i;
    assign tmr_o.stb   = stb_i && (region_d == REGION_TIMER);
    assign tmr_o.we    = we_i;
    assign tmr_o.sel   = sel_i;
    assign tmr_o.adr   = idx;
    assign tmr_o.dat_w = dat_i;

    // Region of the request now in flight
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            region_q_o <= REGION_NONE;
        end else if (req) begin
            region_q_o <= region_d;
        end
    end

endmodule

/* ram/ram_2port_wb.sv */
// Dual-port RAM with a 32-bit instruction fetch port and a 64-bit byte-select data port
`timescale 1ns/1ns
`include "secv_mem_settings.svh"

module ram_2port_wb #(
    parameter bit CLEAR_ON_RESET = `SECV_CLEAR_RAM
) (
    input  logic                            clk_i,
    input  logic                            RESET_MEM,

    // Instruction port
    input  logic                            icyc_i,
    input  logic                            istb_i,
    input  logic [`SECV_INST_WIDTH/8-1:0]   isel_i,
    input  logic [`SECV_IADR_WIDTH-1:0]     iadr_i,
    output logic [`SECV_INST_WIDTH-1:0]     idat_o,
    output logic                            iack_o,

    // Data port
    wb_if.slave                             dbus
);
    import secv_mem_pkg::*;

    localparam int AW    = `SECV_ADDR_WIDTH;
    localparam int IW    = `SECV_INST_WIDTH;
    localparam int DW    = `SECV_DATA_WIDTH;
    localparam int IAW   = `SECV_IADR_WIDTH;
    localparam int ISW   = IW / 8;
    localparam int DEPTH = 2 ** AW;

    logic [DW-1:0] mem [DEPTH];

    logic          ireq;
    logic          dreq;
    logic          dwr;
    logic [DW-1:0] irow;
    logic [IW-1:0] iword;
    logic [IW-1:0] iword_masked;

    assign ireq = icyc_i && istb_i;
    assign dreq = dbus.cyc && dbus.stb;
    assign dwr  = dreq && dbus.we;

    // Two instruction words per row with the odd index in the upper half
    assign irow  = mem[iadr_i[IAW-1:1]];
    assign iword = iadr_i[0] ? irow[2*IW-1:IW] : irow[IW-1:0];

    always_comb begin
        for (int b = 0; b < ISW; b++) begin
            iword_masked[b*8 +: 8] = isel_i[b] ? iword[b*8 +: 8] : 8'h00;
        end
    end

    // Row storage
    always_ff @(posedge clk_i) begin
        if (RESET_MEM && CLEAR_ON_RESET) begin
            for (int r = 0; r < DEPTH; r++) begin
                mem[r] <= '0;
            end
        end else if (dwr) begin
            mem[dbus.adr] <= byte_merge(mem[dbus.adr], dbus.dat_w, dbus.sel);
        end
    end

    // Instruction response one cycle after the request
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            iack_o <= 1'b0;
            idat_o <= '0;
        end else begin
            iack_o <= ireq;
            idat_o <= ireq ? iword_masked : '0;
        end
    end

    // Data response where reads see the row as it was before this edge
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            dbus.ack   <= 1'b0;
            dbus.dat_r <= '0;
        end else begin
            dbus.ack <= dreq;
            if (dreq && !dbus.we) begin
                dbus.dat_r <= byte_mask(mem[dbus.adr], dbus.sel);
            end else begin
                dbus.dat_r <= '0;
            end
        end
    end

endmodule

/* logic/mtimer_regs.sv */
// Machine timer with free-running mtime, mtimecmp and a registered interrupt
`timescale 1ns/1ns
`include "secv_mem_settings.svh"

module mtimer_regs (
    input  logic    clk_i,
    input  logic    RESET_MEM,

    wb_if.slave     bus,

    output logic    timer_irq_o
);
    import secv_mem_pkg::*;

    localparam int AW = `SECV_ADDR_WIDTH;
    localparam int DW = `SECV_DATA_WIDTH;
    localparam logic [AW-1:0] MTIMECMP_IDX = `SECV_MTIMECMP_IDX;

    logic [DW-1:0] mtime_q;
    logic [DW-1:0] mtimecmp_q;
    logic          req;
    logic          wr;
    mtimer_reg_e   reg_sel;

    assign req     = bus.cyc && bus.stb;
    assign wr      = req && bus.we;
    assign reg_sel = (bus.adr == MTIMECMP_IDX) ? MTIMER_MTIMECMP : MTIMER_MTIME;

    // A write replaces the counter increment for that edge
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            mtime_q <= '0;
        end else if (wr && reg_sel == MTIMER_MTIME) begin
            mtime_q <= byte_merge(mtime_q, bus.dat_w, bus.sel);
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    // Compare value starts at all ones so no interrupt fires after reset
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            mtimecmp_q <= '1;
        end else if (wr && reg_sel == MTIMER_MTIMECMP) begin
            mtimecmp_q <= byte_merge(mtimecmp_q, bus.dat_w, bus.sel);
        end
    end

    // Bus response and interrupt
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            bus.ack     <= 1'b0;
            bus.dat_r   <= '0;
            timer_irq_o <= 1'b0;
        end else begin
            bus.ack     <= req;
            timer_irq_o <= (mtime_q >= mtimecmp_q);
            if (req && !bus.we) begin
                bus.dat_r <= byte_mask((reg_sel == MTIMER_MTIMECMP) ? mtimecmp_q : mtime_q,
                                       bus.sel);
            end else begin
                bus.dat_r <= '0;
            end
        end
    end

endmodule

/* logic/wb_resp_mux.sv */
// Data-port response merger that picks ack and read data by region or raises err
`timescale 1ns/1ns
`include "secv_mem_settings.svh"

module wb_resp_mux (
    input  logic                            clk_i,
    input  logic                            RESET_MEM,

    // Raw data-port strobes that flag sampled requests
    input  logic                            cyc_i,
    input  logic                            stb_i,

    input  secv_mem_pkg::region_e           region_q_i,
    wb_if.monitor                           ram_i,
    wb_if.monitor                           tmr_i,

    output logic [`SECV_DATA_WIDTH-1:0]     dat_o,
    output logic                            ack_o,
    output logic                            err_o
);
    import secv_mem_pkg::*;

    logic valid_q;

    // A request was sampled on the previous edge
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= cyc_i && stb_i;
        end
    end

    always_comb begin
        dat_o = '0;
        ack_o = 1'b0;
        err_o = 1'b0;
        case (region_q_i)
            REGION_RAM: begin
                dat_o = ram_i.dat_r;
                ack_o = ram_i.ack;
            end
            REGION_TIMER: begin
                dat_o = tmr_i.dat_r;
                ack_o = tmr_i.ack;
            end
            default: begin
                // Unmapped region answers with err and zero data
                err_o = valid_q;
            end
        endcase
    end

endmodule

/* logic/secv_mem_top.sv */
// Memory subsystem top with Wishbone instruction and data ports and machine timer
`timescale 1ns/1ns
`include "secv_mem_settings.svh"

module secv_mem_top (
    input  logic                            clk_i,
    input  logic                            RESET_MEM,

    // Instruction port
    input  logic                            icyc_i,
    input  logic                            istb_i,
    input  logic [`SECV_INST_WIDTH/8-1:0]   isel_i,
    input  logic [`SECV_IADR_WIDTH-1:0]     iadr_i,
    output logic [`SECV_INST_WIDTH-1:0]     idat_o,
    output logic                            iack_o,

    // Data port
    input  logic                            dcyc_i,
    input  logic                            dstb_i,
    input  logic                            dwe_i,
    input  logic [`SECV_DATA_WIDTH/8-1:0]   dsel_i,
    input  logic [`SECV_DADR_WIDTH-1:0]     dadr_i,
    input  logic [`SECV_DATA_WIDTH-1:0]     ddat_i,
    output logic [`SECV_DATA_WIDTH-1:0]     ddat_o,
    output logic                            dack_o,
    output logic                            derr_o,

    output logic                            timer_irq_o
);
    import secv_mem_pkg::*;

    wb_if ram_bus ();
    wb_if tmr_bus ();

    region_e region_q;

    wb_addr_decoder u_decoder (
        .clk_i      (clk_i),
        .RESET_MEM  (RESET_MEM),
        .cyc_i      (dcyc_i),
        .stb_i      (dstb_i),
        .we_i       (dwe_i),
        .sel_i      (dsel_i),
        .adr_i      (dadr_i),
        .dat_i      (ddat_i),
        .ram_o      (ram_bus.master),
        .tmr_o      (tmr_bus.master),
        .region_q_o (region_q)
    );

    ram_2port_wb #(
        .CLEAR_ON_RESET (`SECV_CLEAR_RAM)
    ) u_ram (
        .clk_i      (clk_i),
        .RESET_MEM  (RESET_MEM),
        .icyc_i     (icyc_i),
        .istb_i     (istb_i),
        .isel_i     (isel_i),
        .iadr_i     (iadr_i),
        .idat_o     (idat_o),
        .iack_o     (iack_o),
        .dbus       (ram_bus.slave)
    );

    mtimer_regs u_timer (
        .clk_i       (clk_i),
        .RESET_MEM   (RESET_MEM),
        .bus         (tmr_bus.slave),
        .timer_irq_o (timer_irq_o)
    );

    wb_resp_mux u_resp (
        .clk_i      (clk_i),
        .RESET_MEM  (RESET_MEM),
        .cyc_i      (dcyc_i),
        .stb_i      (dstb_i),
        .region_q_i (region_q),
        .ram_i      (ram_bus.monitor),
        .tmr_i      (tmr_bus.monitor),
        .dat_o      (ddat_o),
        .ack_o      (dack_o),
        .err_o      (derr_o)
    );

endmodule

/* tests/tb_secv_mem.sv */
// Directed testbench for the memory subsystem with RAM, fetch, timer and error checks
`timescale 1ns/1ns
`include "secv_mem_settings.svh"

module tb_secv_mem;

    localparam int WATCHDOG_CYCLES = 2000;
    localparam int RESP_LIMIT      = 4;
    localparam logic [8:0] MTIME_ADR = 9'h100 + `SECV_MTIME_IDX;
    localparam logic [8:0] CMP_ADR   = 9'h100 + `SECV_MTIMECMP_IDX;

    logic        clk_i = 1'b0;
    logic        RESET_MEM;
    logic        icyc, istb, iack;
    logic [3:0]  isel;
    logic [8:0]  iadr;
    logic [31:0] idat;
    logic        dcyc, dstb, dwe, dack, derr, timer_irq;
    logic [7:0]  dsel;
    logic [8:0]  dadr;
    logic [63:0] ddat_w, ddat_r;

    logic [63:0] model [256];
    int          touched[$];
    int          seed = 95;
    int          errors = 0;
    int          checks = 0;
    int          cycle_cnt = 0;
    int          last_sample;
    string       test_name;

    secv_mem_top DUT (
        .clk_i (clk_i), .RESET_MEM (RESET_MEM),
        .icyc_i (icyc), .istb_i (istb), .isel_i (isel), .iadr_i (iadr),
        .idat_o (idat), .iack_o (iack),
        .dcyc_i (dcyc), .dstb_i (dstb), .dwe_i (dwe), .dsel_i (dsel), .dadr_i (dadr),
        .ddat_i (ddat_w), .ddat_o (ddat_r), .dack_o (dack), .derr_o (derr),
        .timer_irq_o (timer_irq)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // 0xff in every selected byte lane
    function automatic logic [63:0] lane_mask(input logic [7:0] sel);
        logic [63:0] m;
        for (int b = 0; b < 8; b++) begin
            m[b*8 +: 8] = {8{sel[b]}};
        end
        return m;
    endfunction

    function automatic logic [31:0] fetch_expect(input logic [8:0] adr, input logic [3:0] sel);
        logic [63:0] row;
        logic [63:0] mask;
        row  = model[adr[8:1]];
        mask = lane_mask({4'h0, sel});
        return (adr[0] ? row[63:32] : row[31:0]) & mask[31:0];
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic data_access(input logic we, input logic [8:0] adr, input logic [7:0] sel,
                               input logic [63:0] wdat, output logic [63:0] rdat,
                               output logic got_err);
        int waited;
        waited = 0;
        dcyc = 1'b1;
        dstb = 1'b1;
        dwe = we;
        dadr = adr;
        dsel = sel;
        ddat_w = wdat;
        @(negedge clk_i);
        while (!dack && !derr && waited < RESP_LIMIT) begin
            waited++;
            @(negedge clk_i);
        end
        rdat = ddat_r;
        got_err = derr;
        last_sample = cycle_cnt;
        assert (dack || derr) else begin
            $display("%s: data port gave no response at address %h", test_name, adr);
            errors++;
        end
        assert (waited == 0) else begin
            $display("%s: data port answered %0d cycles late", test_name, waited);
            errors++;
        end
        assert (!(dack && derr)) else begin
            $display("%s: data port raised ack and err together", test_name);
            errors++;
        end
        dcyc = 1'b0;
        dstb = 1'b0;
        dwe = 1'b0;
    endtask

    task automatic data_write(input logic [8:0] adr, input logic [7:0] sel, input logic [63:0] d);
        logic [63:0] rdat;
        logic        err;
        data_access(1'b1, adr, sel, d, rdat, err);
        check_value("write err", 64'd0, {63'd0, err});
        if (!adr[8]) begin
            model[adr[7:0]] = (model[adr[7:0]] & ~lane_mask(sel)) | (d & lane_mask(sel));
        end
    endtask

    task automatic data_read(input logic [8:0] adr, input logic [7:0] sel,
                             output logic [63:0] rdat, output logic err);
        data_access(1'b0, adr, sel, 64'd0, rdat, err);
    endtask

    task automatic fetch(input logic [8:0] adr, input logic [3:0] sel, output logic [31:0] word);
        int waited;
        waited = 0;
        icyc = 1'b1;
        istb = 1'b1;
        iadr = adr;
        isel = sel;
        @(negedge clk_i);
        while (!iack && waited < RESP_LIMIT) begin
            waited++;
            @(negedge clk_i);
        end
        word = idat;
        assert (iack) else begin
            $display("%s: instruction port gave no ack at address %h", test_name, adr);
            errors++;
        end
        assert (waited == 0) else begin
            $display("%s: instruction port answered %0d cycles late", test_name, waited);
            errors++;
        end
        icyc = 1'b0;
        istb = 1'b0;
    endtask

    task automatic ram_bytes_test();
        logic [63:0] rd;
        logic [7:0]  sel;
        logic        err;
        int          row;
        test_name = "ram_bytes";
        for (int i = 0; i < 16; i++) begin
            row = $random(seed) & 8'hff;
            touched.push_back(row);
            data_write(row, $random(seed), {$random(seed), $random(seed)});
        end
        foreach (touched[i]) begin
            data_read(touched[i], 8'hff, rd, err);
            check_value("full read", model[touched[i]], rd);
            sel = $random(seed);
            data_read(touched[i], sel, rd, err);
            check_value("partial read", model[touched[i]] & lane_mask(sel), rd);
        end
    endtask

    task automatic fetch_test();
        logic [31:0] word;
        test_name = "fetch";
        for (int r = 200; r < 204; r++) begin
            data_write(r, 8'hff, {$random(seed), $random(seed)});
        end
        for (int a = 400; a < 408; a++) begin
            fetch(a, 4'hf, word);
            check_value("full fetch", fetch_expect(a, 4'hf), word);
            fetch(a, 4'b0101, word);
            check_value("masked fetch", fetch_expect(a, 4'b0101), word);
        end
        // Fetch and an unrelated data write sampled on the same edge
        icyc = 1'b1;
        istb = 1'b1;
        iadr = 9'd401;
        isel = 4'hf;
        data_write(9'd10, 8'hff, {$random(seed), $random(seed)});
        check_value("fetch beside write", fetch_expect(9'd401, 4'hf), idat);
        check_value("fetch ack beside write", 64'd1, {63'd0, iack});
        icyc = 1'b0;
        istb = 1'b0;
    endtask

    task automatic counter_test();
        logic [63:0] v;
        logic [63:0] rd;
        logic        err;
        int          c1;
        test_name = "counter";
        v = {1'b0, 31'($random(seed)), 32'($random(seed))};
        data_write(MTIME_ADR, 8'hff, v);
        c1 = last_sample;
        repeat (5) @(negedge clk_i);
        data_read(MTIME_ADR, 8'hff, rd, err);
        // Read sees the value held before its own sampling edge
        check_value("mtime", v + (last_sample - c1 - 1), rd);
    endtask

    task automatic interrupt_test();
        logic [63:0] t;
        logic        err;
        int          c1;
        test_name = "interrupt";
        data_read(MTIME_ADR, 8'hff, t, err);
        c1 = last_sample;
        data_write(CMP_ADR, 8'hff, t + 20);
        check_value("irq before match", 64'd0, {63'd0, timer_irq});
        while (!timer_irq && cycle_cnt < c1 + 40) begin
            @(negedge clk_i);
        end
        check_value("irq rise cycle", c1 + 20, cycle_cnt);
        data_write(CMP_ADR, 8'hff, '1);
        @(negedge clk_i);
        check_value("irq after rewrite", 64'd0, {63'd0, timer_irq});
    endtask

    task automatic unmapped_test();
        logic [63:0] rd;
        logic        err;
        test_name = "unmapped";
        data_read(9'h102, 8'hff, rd, err);
        check_value("err idx 2", 64'd1, {63'd0, err});
        check_value("data idx 2", 64'd0, rd);
        data_read(9'h1ff, 8'hff, rd, err);
        check_value("err idx 255", 64'd1, {63'd0, err});
        data_read(touched[0], 8'hff, rd, err);
        check_value("ram after err", model[touched[0]], rd);
        check_value("ram err flag", 64'd0, {63'd0, err});
    endtask

    task automatic reset_clear_test();
        logic [63:0] rd;
        logic [31:0] word;
        logic        err;
        test_name = "reset_clear";
        RESET_MEM = 1'b1;
        repeat (3) @(negedge clk_i);
        RESET_MEM = 1'b0;
        foreach (model[i]) begin
            model[i] = '0;
        end
        data_read(MTIME_ADR, 8'hff, rd, err);
        check_value("mtime after reset", 64'd0, rd);
        check_value("irq after reset", 64'd0, {63'd0, timer_irq});
        data_read(CMP_ADR, 8'hff, rd, err);
        check_value("mtimecmp after reset", '1, rd);
        for (int r = 200; r < 204; r++) begin
            touched.push_back(r);
        end
        foreach (touched[i]) begin
            data_read(touched[i], 8'hff, rd, err);
            check_value("row cleared", 64'd0, rd);
        end
        fetch(9'd401, 4'hf, word);
        check_value("fetch cleared", 64'd0, word);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        RESET_MEM = 1'b1;
        {icyc, istb, isel, iadr} = '0;
        {dcyc, dstb, dwe, dsel, dadr, ddat_w} = '0;
        foreach (model[i]) begin
            model[i] = '0;
        end
        repeat (3) @(negedge clk_i);
        RESET_MEM = 1'b0;
        ram_bytes_test();
        fetch_test();
        counter_test();
        interrupt_test();
        unmapped_test();
        reset_clear_test();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+common
common/secv_mem_pkg.sv
common/wb_if.sv
logic/wb_addr_decoder.sv
ram/ram_2port_wb.sv
logic/mtimer_regs.sv
logic/wb_resp_mux.sv
logic/secv_mem_top.sv
tests/tb_secv_mem.sv
